/* nes_bus_pkg.sv */
// CPU package bus constants, register map and shared enums
package nes_bus_pkg;

	// Master clock division
	localparam logic [3:0] CPU_DIV           = 4'd12;          // Master clocks per CPU cycle
	localparam logic [2:0] PPU_DIV           = 3'd4;           // Master clocks per PPU cycle
	localparam logic [3:0] CART_CE_POS       = CPU_DIV - 4'd2; // First PPU tick with CPU data
	localparam logic [2:0] PAL_STRETCH_EVERY = 3'd5;           // One long CPU cycle in five

	// Bus widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// Register addresses
	localparam logic [15:0] OAM_DMA_REG  = 16'h4014; // Sprite DMA page write
	localparam logic [15:0] OAM_DATA_REG = 16'h2004; // Sprite DMA target
	localparam logic [15:0] JOY1_REG     = 16'h4016; // Strobe on write, port 1 on read
	localparam logic [15:0] JOY2_REG     = 16'h4017;

	// $4000-$401F, upper 11 address bits
	localparam logic [10:0] APU_PAGE = 11'b0100_0000_000;

	// Console timing family
	typedef enum logic [1:0] {
		NTSC  = 2'd0,
		PAL   = 2'd1,
		DENDY = 2'd2 // Same divider as NTSC
	} sys_type_e;

	// Sprite DMA progress
	typedef enum logic [1:0] {
		SPR_IDLE = 2'b00,
		SPR_WAIT = 2'b01, // CPU halted, waiting for a get cycle
		SPR_RUN  = 2'b11  // Read/write pairs in flight
	} spr_state_e;

	// DMC sample fetch
	typedef enum logic {
		DMC_IDLE  = 1'b0,
		DMC_FETCH = 1'b1
	} dmc_state_e;

	// Source of the byte returned on a read
	typedef enum logic [2:0] {
		SEL_JOY1 = 3'd0,
		SEL_JOY2 = 3'd1,
		SEL_PPU  = 3'd2,
		SEL_PRG  = 3'd3,
		SEL_OPEN = 3'd4
	} bus_sel_e;

endpackage

/* dma_bus_if.sv */
// DMA bus request from the DMA engine to the bus mux and read-return path
`timescale 1ns/1ps

interface dma_bus_if import nes_bus_pkg::*; ();

	logic [ADDR_W-1:0] addr;  // Address the DMA puts on the bus
	logic              en;    // DMA owns the bus this CPU cycle
	logic              read;  // 1 = read, 0 = write
	logic [DATA_W-1:0] wdata; // Byte for $2004 on put cycles

	// Driver side, the DMA engine
	modport dma (
		output addr,
		output en,
		output read,
		output wdata
	);

	// Consumers of the request
	modport sink (
		input addr,
		input en,
		input read,
		input wdata
	);

endinterface

/* nes_clock_div.sv */
// Master clock divider for CPU, PPU and cartridge enables with get/put tracking
`timescale 1ns/1ps

module nes_clock_div import nes_bus_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  sys_type_e sys_type,
	output logic      cpu_ce,
	output logic      ppu_ce,
	output logic      cart_ce,
	output logic      put_cycle,
	output logic      put_ce,
	output logic      get_ce
);

	logic [3:0] div_cpu;       // 1..12, 0 only after reset or realign
	logic [2:0] div_ppu;       // 1..4
	logic [1:0] ppu_tick;      // PPU ticks since last cpu_ce
	logic [2:0] pal_cnt;       // CPU cycle index inside the PAL group of five
	sys_type_e  last_sys_type;
	logic       pal;
	logic       stretch;
	logic       realign;

	assign pal     = (sys_type == PAL); // Dendy keeps the NTSC divider
	assign realign = (sys_type != last_sys_type);

	// Last cycle of the group holds the CPU counter for its first PPU tick
	assign stretch = pal && (pal_cnt == PAL_STRETCH_EVERY - 3'd1) && (ppu_tick == 2'd0);

	assign cpu_ce  = (div_cpu == CPU_DIV);
	assign ppu_ce  = (div_ppu == PPU_DIV);
	assign cart_ce = (div_cpu == CART_CE_POS); // Two clocks ahead of cpu_ce
	assign put_ce  = cpu_ce && put_cycle;
	assign get_ce  = cpu_ce && !put_cycle;

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cpu       <= 4'd0;
			div_ppu       <= 3'd0;
			ppu_tick      <= 2'd0;
			pal_cnt       <= 3'd0;
			put_cycle     <= 1'b1; // First CPU cycle is a put
			last_sys_type <= sys_type;
		end else begin
			if (cpu_ce)
				put_cycle <= !put_cycle;
			last_sys_type <= sys_type;

			if (realign) begin
				// Restart all counters in phase
				div_cpu  <= 4'd0;
				div_ppu  <= 3'd0;
				ppu_tick <= 2'd0;
				pal_cnt  <= 3'd0;
			end else begin
				if (!stretch)
					div_cpu <= cpu_ce ? 4'd1 : div_cpu + 4'd1;
				div_ppu <= ppu_ce ? 3'd1 : div_ppu + 3'd1;

				if (cpu_ce)
					ppu_tick <= 2'd0;
				else if (ppu_ce)
					ppu_tick <= ppu_tick + 2'd1;

				if (cpu_ce) begin
					if (!pal || pal_cnt == PAL_STRETCH_EVERY - 3'd1)
						pal_cnt <= 3'd0;
					else
						pal_cnt <= pal_cnt + 3'd1;
				end
			end
		end
	end

	// Cartridge enable leads the CPU enable by two clocks, PAL stretch included
	cart_leads_cpu: assert property (@(posedge clk) disable iff (reset || realign)
		cart_ce |-> !cpu_ce ##2 cpu_ce);

endmodule

/* io_decode.sv */
// Bus address decoder with joypad strobe latch and joypad clock pulses
`timescale 1ns/1ps

module io_decode import nes_bus_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic [ADDR_W-1:0] bus_addr,
	input  logic              bus_read,
	input  logic              cpu_write,
	input  logic [DATA_W-1:0] cpu_dout,
	input  logic              put_ce,
	output bus_sel_e          sel,
	output logic              oam_dma_write,
	output logic [2:0]        joypad_out,
	output logic [1:0]        joypad_clock
);

	logic       apu_cs;
	logic       joy1_cs;
	logic       joy2_cs;
	logic       ppu_cs;
	logic       strobe_wr;
	logic [2:0] joy_latch; // Last value written to $4016

	assign apu_cs  = (bus_addr[ADDR_W-1:5] == APU_PAGE);
	assign joy1_cs = apu_cs && (bus_addr[4:0] == JOY1_REG[4:0]);
	assign joy2_cs = apu_cs && (bus_addr[4:0] == JOY2_REG[4:0]);
	assign ppu_cs  = (bus_addr[ADDR_W-1:13] == 3'b001); // $2000-$3FFF, mirrored regs

	assign strobe_wr     = joy1_cs && cpu_write;
	assign oam_dma_write = cpu_write && (bus_addr == OAM_DMA_REG);

	// One pulse per read of each port
	assign joypad_clock = {joy2_cs && bus_read, joy1_cs && bus_read};

	always_comb begin
		if (joy1_cs)
			sel = SEL_JOY1;
		else if (joy2_cs)
			sel = SEL_JOY2;
		else if (ppu_cs)
			sel = SEL_PPU;
		else if (apu_cs)
			sel = SEL_OPEN; // APU registers not driven here
		else
			sel = SEL_PRG;  // Cartridge space and internal RAM
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			joy_latch  <= 3'd0;
			joypad_out <= 3'd0;
		end else begin
			if (strobe_wr)
				joy_latch <= cpu_dout[2:0];
			// Pins only change on the put edge
			if (put_ce)
				joypad_out <= strobe_wr ? cpu_dout[2:0] : joy_latch;
		end
	end

endmodule

/* dma_engine.sv */
// Sprite and DMC DMA engine with CPU halt and bus takeover
`timescale 1ns/1ps

module dma_engine import nes_bus_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              cpu_ce,
	input  logic              put_cycle,
	input  logic              put_ce,
	input  logic              get_ce,
	input  logic              oam_dma_write,
	input  logic              cpu_rnw,
	input  logic [DATA_W-1:0] cpu_dout,
	input  logic              dmc_req,
	input  logic [ADDR_W-1:0] dmc_addr,
	input  logic [DATA_W-1:0] rdata,
	output logic              pause_cpu,
	output logic              dmc_ack,
	dma_bus_if.dma            dma
);

	spr_state_e        spr_state;
	dmc_state_e        dmc_state;
	logic [ADDR_W-1:0] spr_addr;  // Source address, page fixed by the $4014 write
	logic [DATA_W-1:0] spr_data;  // Byte read, waiting for its $2004 write
	logic              spr_have;  // spr_data still owed to $2004
	logic              spr_last;  // Byte at xxFF has been read
	logic [8:0]        next_lo;   // Low address byte plus carry
	logic              spr_start;
	logic              spr_rd;
	logic              spr_wr;
	logic              spr_fetch;

	assign next_lo   = {1'b0, spr_addr[7:0]} + 9'd1;
	assign spr_start = (spr_state == SPR_IDLE) && oam_dma_write && cpu_ce;

	// DMC owns the get cycle of its fetch
	assign dmc_ack = (dmc_state == DMC_FETCH) && !put_cycle;

	// Sprite read on free get cycles, write only when a byte is held
	assign spr_rd    = (spr_state == SPR_RUN) && !put_cycle && !dmc_ack;
	assign spr_wr    = (spr_state == SPR_RUN) && put_cycle && spr_have;
	assign spr_fetch = spr_rd && get_ce;

	assign pause_cpu = (spr_state != SPR_IDLE) || dmc_req || (dmc_state == DMC_FETCH);

	assign dma.en    = dmc_ack || spr_rd || spr_wr; // Idle cycles leave the bus to the CPU
	assign dma.read  = !put_cycle;
	assign dma.addr  = dmc_ack ? dmc_addr : (put_cycle ? OAM_DATA_REG : spr_addr);
	assign dma.wdata = spr_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= SPR_IDLE;
			dmc_state <= DMC_IDLE;
			spr_have  <= 1'b0;
			spr_last  <= 1'b0;
		end else begin
			// DMC enters on a put edge so the fetch lands on the next get
			if (dmc_state == DMC_IDLE && dmc_req && cpu_rnw && put_ce)
				dmc_state <= DMC_FETCH;
			else if (dmc_state == DMC_FETCH && put_ce)
				dmc_state <= DMC_IDLE;

			case (spr_state)
				SPR_IDLE: begin
					if (spr_start) begin
						spr_state <= SPR_WAIT;
						spr_have  <= 1'b0;
						spr_last  <= 1'b0;
					end
				end
				SPR_WAIT: begin
					if (get_ce && cpu_rnw) // CPU must be stopped in a read
						spr_state <= SPR_RUN;
				end
				SPR_RUN: begin
					if (spr_fetch) begin
						spr_have <= 1'b1;
						spr_last <= next_lo[8];
					end
					if (spr_wr && put_ce) begin
						spr_have <= 1'b0;
						if (spr_last)
							spr_state <= SPR_IDLE; // 256th write done
					end
				end
				default: spr_state <= SPR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (spr_start)
			spr_addr <= {cpu_dout, 8'h00};
		if (spr_fetch) begin
			spr_addr[7:0] <= next_lo[7:0];
			spr_data      <= rdata; // Return path value at the end of the get cycle
		end
	end

	dma_en_paused: assert property (@(posedge clk) disable iff (reset)
		dma.en |-> pause_cpu);

endmodule

/* bus_return.sv */
// Read data selection for CPU and DMA with the open bus latch
`timescale 1ns/1ps

module bus_return import nes_bus_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              cpu_ce,
	input  bus_sel_e          sel,
	input  logic [4:0]        joypad1_data,
	input  logic [4:0]        joypad2_data,
	input  logic [DATA_W-1:0] ppu_dout,
	input  logic [DATA_W-1:0] prg_din,
	input  logic              prg_allow,
	input  logic [DATA_W-1:0] bus_dout,
	input  logic              bus_write,
	dma_bus_if.sink           dma,
	output logic [DATA_W-1:0] rdata
);

	logic [DATA_W-1:0] open_bus;    // Last value seen on the data bus
	logic [DATA_W-1:0] prg_or_open;
	logic [DATA_W-1:0] joy_top;     // Source of the undriven joypad bits
	logic [4:0]        joy_data;

	assign prg_or_open = prg_allow ? prg_din : open_bus;
	assign joy_data    = (sel == SEL_JOY2) ? joypad2_data : joypad1_data;

	// DMA sees the external bus in the top bits, the CPU sees open bus
	assign joy_top = dma.en ? prg_or_open : open_bus;

	always_comb begin
		case (sel)
			SEL_JOY1,
			SEL_JOY2: rdata = {joy_top[DATA_W-1:5], joy_data};
			SEL_PPU:  rdata = ppu_dout;
			SEL_PRG:  rdata = prg_or_open; // Unmapped PRG floats
			default:  rdata = open_bus;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			open_bus <= '0;
		else if (!cpu_ce) // Held on the CPU edge so the read sees the old value
			open_bus <= bus_write ? bus_dout : rdata;
	end

endmodule

/* nes_bus_core.sv */
// CPU package bus side joining clocks, decode, DMA and read return
`timescale 1ns/1ps

module nes_bus_core import nes_bus_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic [ADDR_W-1:0] cpu_addr,
	input  logic [DATA_W-1:0] cpu_dout,
	input  logic              cpu_rnw,
	input  logic              dmc_req,
	input  logic [ADDR_W-1:0] dmc_addr,
	input  sys_type_e         sys_type,
	input  logic [4:0]        joypad1_data,
	input  logic [4:0]        joypad2_data,
	input  logic [DATA_W-1:0] ppu_dout,
	input  logic [DATA_W-1:0] prg_din,
	input  logic              prg_allow,
	output logic              cpu_ce,
	output logic              ppu_ce,
	output logic              cart_ce,
	output logic [ADDR_W-1:0] bus_addr,
	output logic [DATA_W-1:0] bus_dout,
	output logic              bus_read,
	output logic              bus_write,
	output logic [DATA_W-1:0] cpu_din,
	output logic              pause_cpu,
	output logic              dmc_ack,
	output logic [2:0]        joypad_out,
	output logic [1:0]        joypad_clock
);

	logic              put_cycle;
	logic              put_ce;
	logic              get_ce;
	logic              cpu_write;     // CPU write that reaches the bus
	logic              oam_dma_write;
	bus_sel_e          sel;
	logic [DATA_W-1:0] rdata;

	dma_bus_if dma_bus ();

	// DMA takes the whole bus while enabled
	assign bus_addr  = dma_bus.en ? dma_bus.addr : cpu_addr;
	assign bus_dout  = dma_bus.en ? dma_bus.wdata : cpu_dout;
	assign bus_read  = dma_bus.en ? dma_bus.read : cpu_rnw;
	assign bus_write = dma_bus.en ? !dma_bus.read : !cpu_rnw;
	assign cpu_write = !dma_bus.en && !cpu_rnw;
	assign cpu_din   = rdata;

	nes_clock_div u_clock_div (
		.clk       (clk),
		.reset     (reset),
		.sys_type  (sys_type),
		.cpu_ce    (cpu_ce),
		.ppu_ce    (ppu_ce),
		.cart_ce   (cart_ce),
		.put_cycle (put_cycle),
		.put_ce    (put_ce),
		.get_ce    (get_ce)
	);

	io_decode u_io_decode (
		.clk           (clk),
		.reset         (reset),
		.bus_addr      (bus_addr),
		.bus_read      (bus_read),
		.cpu_write     (cpu_write),
		.cpu_dout      (cpu_dout),
		.put_ce        (put_ce),
		.sel           (sel),
		.oam_dma_write (oam_dma_write),
		.joypad_out    (joypad_out),
		.joypad_clock  (joypad_clock)
	);

	dma_engine u_dma_engine (
		.clk           (clk),
		.reset         (reset),
		.cpu_ce        (cpu_ce),
		.put_cycle     (put_cycle),
		.put_ce        (put_ce),
		.get_ce        (get_ce),
		.oam_dma_write (oam_dma_write),
		.cpu_rnw       (cpu_rnw),
		.cpu_dout      (cpu_dout),
		.dmc_req       (dmc_req),
		.dmc_addr      (dmc_addr),
		.rdata         (rdata),
		.pause_cpu     (pause_cpu),
		.dmc_ack       (dmc_ack),
		.dma           (dma_bus)
	);

	bus_return u_bus_return (
		.clk          (clk),
		.reset        (reset),
		.cpu_ce       (cpu_ce),
		.sel          (sel),
		.joypad1_data (joypad1_data),
		.joypad2_data (joypad2_data),
		.ppu_dout     (ppu_dout),
		.prg_din      (prg_din),
		.prg_allow    (prg_allow),
		.bus_dout     (bus_dout),
		.bus_write    (bus_write),
		.dma          (dma_bus),
		.rdata        (rdata)
	);

endmodule

/* tb_nes_bus_core.sv */
// Testbench for the CPU package bus side with a PRG memory model and assertion checks
`timescale 1ns/1ps

module tb_nes_bus_core import nes_bus_pkg::*; ();

	typedef enum int {
		EV_CPU_CE,
		EV_PPU_CE,
		EV_CART_CE,
		EV_DMA_DONE,
		EV_DMC_ACK,
		EV_WRITES_SEEN // Enough sprite writes to interrupt with a DMC fetch
	} wait_e;

	logic              clk;
	logic              reset;
	logic [ADDR_W-1:0] cpu_addr;
	logic [DATA_W-1:0] cpu_dout;
	logic              cpu_rnw;
	logic              dmc_req;
	logic [ADDR_W-1:0] dmc_addr;
	sys_type_e         sys_type;
	logic [4:0]        joypad1_data;
	logic [4:0]        joypad2_data;
	logic [DATA_W-1:0] ppu_dout;
	logic [DATA_W-1:0] prg_din;
	logic              prg_allow;
	logic              cpu_ce;
	logic              ppu_ce;
	logic              cart_ce;
	logic [ADDR_W-1:0] bus_addr;
	logic [DATA_W-1:0] bus_dout;
	logic              bus_read;
	logic              bus_write;
	logic [DATA_W-1:0] cpu_din;
	logic              pause_cpu;
	logic              dmc_ack;
	logic [2:0]        joypad_out;
	logic [1:0]        joypad_clock;

	int          errors;           // Failed checks in the test sequence
	int          mon_errors = 0;   // Failed checks in the $2004 monitor
	int          write_count = 0;  // Sprite writes seen so far
	int          base_count;       // write_count when the current DMA began
	int          tests_run;
	int          tests_failed;
	logic [15:0] dma_base;         // Source page of the current DMA

	// PRG model, every address bit reaches the byte
	function automatic logic [DATA_W-1:0] prg_byte(input logic [ADDR_W-1:0] a);
		return a[7:0] ^ {a[12:8], a[15:13]} ^ 8'hA5;
	endfunction

	assign prg_din = prg_byte(bus_addr);

	nes_bus_core uut (
		.clk          (clk),
		.reset        (reset),
		.cpu_addr     (cpu_addr),
		.cpu_dout     (cpu_dout),
		.cpu_rnw      (cpu_rnw),
		.dmc_req      (dmc_req),
		.dmc_addr     (dmc_addr),
		.sys_type     (sys_type),
		.joypad1_data (joypad1_data),
		.joypad2_data (joypad2_data),
		.ppu_dout     (ppu_dout),
		.prg_din      (prg_din),
		.prg_allow    (prg_allow),
		.cpu_ce       (cpu_ce),
		.ppu_ce       (ppu_ce),
		.cart_ce      (cart_ce),
		.bus_addr     (bus_addr),
		.bus_dout     (bus_dout),
		.bus_read     (bus_read),
		.bus_write    (bus_write),
		.cpu_din      (cpu_din),
		.pause_cpu    (pause_cpu),
		.dmc_ack      (dmc_ack),
		.joypad_out   (joypad_out),
		.joypad_clock (joypad_clock)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	// Each $2004 write must carry the source byte of its position in the page
	always @(posedge clk) begin
		if (!reset && cpu_ce && bus_write && pause_cpu && bus_addr == OAM_DATA_REG) begin
			assert (bus_dout == prg_byte(dma_base + 16'(write_count - base_count))) else begin
				$display("ERR %0t: sprite write %0d carried %h, expected %h", $time,
					write_count - base_count, bus_dout,
					prg_byte(dma_base + 16'(write_count - base_count)));
				mon_errors <= mon_errors + 1;
			end
			write_count <= write_count + 1;
		end
	end

	function automatic logic cond_met(input wait_e which);
		case (which)
			EV_CPU_CE:   return cpu_ce;
			EV_PPU_CE:   return ppu_ce;
			EV_CART_CE:  return cart_ce;
			EV_DMA_DONE: return !pause_cpu;
			EV_DMC_ACK:  return dmc_ack;
			default:     return (write_count - base_count) >= 40;
		endcase
	endfunction

	// Clocks until the event shows at a rising edge, bounded by limit
	task automatic wait_for(input wait_e which, input int limit, output int n);
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!cond_met(which) && n < limit);
		if (!cond_met(which)) begin
			$display("Timeout after %0d clocks waiting for %s", limit, which.name());
			errors++;
		end
	endtask

	task automatic verify(input logic ok, input string msg);
		assert (ok) else begin
			$display("ERR %0t: %s", $time, msg);
			errors++;
		end
	endtask

	// One CPU access held until its cpu_ce, din is the byte the CPU reads
	task automatic cpu_access(input logic [15:0] addr, input logic rnw,
		input logic [7:0] data, input logic allow, output logic [7:0] din);
		int n;
		#1;
		cpu_addr  = addr;
		cpu_rnw   = rnw;
		cpu_dout  = data;
		prg_allow = allow;
		wait_for(EV_CPU_CE, 64, n);
		din = cpu_din;
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (errors + mon_errors == errs_before) begin
			$display("PASS %s", name);
		end else begin
			tests_failed++;
			$display("FAIL %s", name);
		end
	endtask

	initial begin
		int         n;
		int         total;
		int         long_count;
		int         start_errs;
		logic [7:0] din;
		logic [7:0] joy_val;

		void'($urandom(83));
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		reset        = 1'b1;
		cpu_addr     = 16'h8000;
		cpu_dout     = 8'h00;
		cpu_rnw      = 1'b1;
		dmc_req      = 1'b0;
		dmc_addr     = 16'hC123;
		sys_type     = NTSC;
		joypad1_data = 5'h13;
		joypad2_data = 5'h0A;
		ppu_dout     = 8'h3C;
		prg_allow    = 1'b1;
		base_count   = 0;
		dma_base     = 16'h0300;
		repeat (2) @(posedge clk);
		#1 reset = 1'b0;

		// NTSC spacing of the enables, the cpu_ce edge also carries a ppu_ce
		start_errs = errors + mon_errors;
		wait_for(EV_CPU_CE, 64, n);
		repeat (4) begin
			wait_for(EV_CPU_CE, 64, n);
			verify(n == 12, $sformatf("cpu_ce interval %0d, expected 12", n));
		end
		repeat (4) begin
			wait_for(EV_PPU_CE, 64, n);
			verify(n == 4, $sformatf("ppu_ce interval %0d, expected 4", n));
		end
		repeat (4) begin
			wait_for(EV_CART_CE, 64, n);
			wait_for(EV_CPU_CE, 64, n);
			verify(n == 2, $sformatf("cart_ce leads cpu_ce by %0d, expected 2", n));
		end
		finish_test("NTSC enables", start_errs);

		// PAL, one CPU cycle in five lasts 16 clocks
		start_errs = errors + mon_errors;
		#1 sys_type = PAL;
		wait_for(EV_CPU_CE, 64, n); // Realigned cycle, not measured
		total      = 0;
		long_count = 0;
		repeat (5) begin
			wait_for(EV_CPU_CE, 64, n);
			total += n;
			if (n == 16)
				long_count++;
			verify(n == 12 || n == 16, $sformatf("PAL cpu_ce interval %0d", n));
		end
		verify(total == 64, $sformatf("five PAL cycles took %0d clocks, expected 64", total));
		verify(long_count == 1, $sformatf("%0d stretched cycles, expected 1", long_count));
		#1 sys_type = NTSC;
		wait_for(EV_CPU_CE, 64, n);
		finish_test("PAL stretch", start_errs);

		// Sprite DMA from page $03
		start_errs = errors + mon_errors;
		base_count = write_count;
		dma_base   = 16'h0300;
		cpu_access(OAM_DMA_REG, 1'b0, 8'h03, 1'b1, din);
		#1;
		cpu_rnw  = 1'b1; // CPU halts in a read
		cpu_addr = 16'h8000;
		@(posedge clk);
		verify(pause_cpu, "pause_cpu low in the cycle after the $4014 write");
		wait_for(EV_DMA_DONE, 8000, n);
		verify(write_count - base_count == 256,
			$sformatf("%0d sprite writes, expected 256", write_count - base_count));
		finish_test("Sprite DMA", start_errs);

		// DMC fetch steals a get cycle in the middle of a page $05 copy
		start_errs = errors + mon_errors;
		base_count = write_count;
		dma_base   = 16'h0500;
		cpu_access(OAM_DMA_REG, 1'b0, 8'h05, 1'b1, din);
		#1;
		cpu_rnw  = 1'b1;
		cpu_addr = 16'h8000;
		wait_for(EV_WRITES_SEEN, 4000, n);
		#1 dmc_req = 1'b1;
		wait_for(EV_DMC_ACK, 100, n);
		verify(bus_addr == dmc_addr && bus_read,
			$sformatf("DMC fetch at %h, expected a read of %h", bus_addr, dmc_addr));
		#1 dmc_req = 1'b0; // Request drops once acknowledged
		wait_for(EV_DMA_DONE, 8000, n);
		verify(write_count - base_count == 256,
			$sformatf("%0d sprite writes, expected 256", write_count - base_count));
		finish_test("DMC fetch", start_errs);

		// Read return, the write of $46 leaves its top bits on the open bus
		start_errs = errors + mon_errors;
		cpu_access(16'h0200, 1'b0, 8'h46, 1'b1, din);
		cpu_access(JOY1_REG, 1'b1, 8'h00, 1'b1, din);
		verify(din == {3'b010, joypad1_data}, $sformatf("$4016 read %h", din));
		verify(joypad_clock == 2'b01, $sformatf("joypad_clock %b on $4016 read", joypad_clock));
		cpu_access(16'h2002, 1'b1, 8'h00, 1'b1, din);
		verify(din == ppu_dout, $sformatf("PPU read %h, expected %h", din, ppu_dout));
		cpu_access(16'h8000, 1'b1, 8'h00, 1'b0, din); // Last bus byte came from the PPU
		verify(din == ppu_dout, $sformatf("open bus read %h, expected %h", din, ppu_dout));
		finish_test("Read return", start_errs);

		// Joypad strobe, two more CPU cycles always hold a put edge
		start_errs = errors + mon_errors;
		joy_val    = 8'($urandom());
		if (joy_val[2:0] == joypad_out)
			joy_val[2:0] = ~joypad_out; // Pins must visibly change
		cpu_access(JOY1_REG, 1'b0, joy_val, 1'b1, din);
		cpu_access(16'h8000, 1'b1, 8'h00, 1'b1, din);
		cpu_access(16'h8000, 1'b1, 8'h00, 1'b1, din);
		verify(joypad_out == joy_val[2:0],
			$sformatf("joypad_out %b, expected %b", joypad_out, joy_val[2:0]));
		finish_test("Joypad strobe", start_errs);

		$display("Tests run %0d, failed %0d, failed checks %0d", tests_run, tests_failed,
			errors + mon_errors);
		if (errors + mon_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* nes_bus_core.f */
nes_bus_pkg.sv
dma_bus_if.sv
nes_clock_div.sv
io_decode.sv
dma_engine.sv
bus_return.sv
nes_bus_core.sv
tb_nes_bus_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_nes_bus_core
FILELIST  ?= nes_bus_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
